/* bench/ex_stage_input.txt */
// hex fields: v ctl cls wid sgn fwa fwb op fn sh rt rd da db imm memwb exmem res d4m wr ex
// ctl 6 stall 5 halt 4 reg_dst 3 mem2reg 2 mem_write 1 imm_flag 0 reg_write, ex 5 sign 4:3 width 2:0 rw mw m2r
// r-type alu operations
1_11_2_2_0_0_0_00_20_00_02_03_00000005_00000007_00000000_0000b0b0_0000e0e0_0000000c_00000007_03_14
1_11_2_2_0_0_0_00_22_00_04_05_00000003_00000005_00000000_0000b0b0_0000e0e0_fffffffe_00000005_05_14
1_11_2_2_0_0_0_00_24_00_04_06_f0f0ff00_0ff00ff0_00000000_0000b0b0_0000e0e0_00f00f00_0ff00ff0_06_14
1_11_2_2_0_0_0_00_25_00_04_07_f0f0ff00_0ff00ff0_00000000_0000b0b0_0000e0e0_fff0fff0_0ff00ff0_07_14
1_11_2_2_0_0_0_00_26_00_04_08_f0f0ff00_0ff00ff0_00000000_0000b0b0_0000e0e0_ff00f0f0_0ff00ff0_08_14
1_11_2_2_0_0_0_00_27_00_04_09_f0f0ff00_0ff00ff0_00000000_0000b0b0_0000e0e0_000f000f_0ff00ff0_09_14
1_11_2_2_0_0_0_00_2a_00_04_0a_ffffffff_00000001_00000000_0000b0b0_0000e0e0_00000001_00000001_0a_14
1_11_2_2_0_0_0_00_2b_00_04_0b_ffffffff_00000001_00000000_0000b0b0_0000e0e0_00000000_00000001_0b_14
1_11_2_2_0_0_0_00_00_04_04_0c_00000000_0000000f_00000000_0000b0b0_0000e0e0_000000f0_0000000f_0c_14
1_11_2_2_0_0_0_00_02_08_04_0d_00000000_80000000_00000000_0000b0b0_0000e0e0_00800000_80000000_0d_14
1_11_2_2_0_0_0_00_03_08_04_0e_00000000_80000000_00000000_0000b0b0_0000e0e0_ff800000_80000000_0e_14
1_11_2_2_0_0_0_00_07_00_04_0f_00000024_80000000_00000000_0000b0b0_0000e0e0_f8000000_80000000_0f_14
1_11_2_2_0_0_0_00_04_00_04_10_00000003_00000001_00000000_0000b0b0_0000e0e0_00000008_00000001_10_14
// i-type, load/store and branch classes
1_03_3_2_0_0_0_08_00_00_08_09_00000010_12345678_fffffff0_0000b0b0_0000e0e0_00000000_12345678_08_14
1_03_3_2_0_0_0_0f_00_00_08_09_00000000_00000000_00001234_0000b0b0_0000e0e0_12340000_00000000_08_14
1_03_3_2_0_0_0_0a_00_00_08_09_fffffffe_00000000_00000001_0000b0b0_0000e0e0_00000001_00000000_08_14
1_03_3_2_0_0_0_0d_00_00_08_09_0000ff00_00000000_000000ff_0000b0b0_0000e0e0_0000ffff_00000000_08_14
1_0b_0_2_1_0_0_23_00_00_0a_00_00001000_00000000_00000004_0000b0b0_0000e0e0_00001004_00000000_0a_35
1_06_0_1_0_0_0_2b_00_00_0b_00_00002000_cafef00d_00000008_0000b0b0_0000e0e0_00002008_cafef00d_0b_0a
1_00_1_2_0_0_0_04_00_00_0c_00_00000005_00000005_00000000_0000b0b0_0000e0e0_00000000_00000005_0c_10
// forwarding, link bypass and immediate override
1_11_2_2_0_3_2_00_20_00_01_02_11111111_22222222_00000000_0000b0b0_0000e0e0_00019190_0000b0b0_02_14
1_11_2_2_0_2_3_00_20_00_01_02_11111111_22222222_00000000_0000b0b0_0000e0e0_00019190_0000e0e0_02_14
1_11_2_2_0_1_0_00_20_00_01_02_11111111_22222222_00000000_0000b0b0_0000e0e0_22222222_22222222_02_14
1_11_2_2_0_0_1_00_20_00_01_02_11111111_22222222_00000000_0000b0b0_0000e0e0_11111111_00000000_02_14
1_01_0_2_0_3_3_03_00_00_1f_00_00400000_00000008_00000000_0000b0b0_0000e0e0_00400008_0000e0e0_1f_14
1_11_0_2_0_2_2_00_09_00_00_1f_00400010_00000004_00000000_0000b0b0_0000e0e0_00400014_0000b0b0_1f_14
1_03_3_2_0_0_3_08_00_00_0d_00_00000001_00000000_00000100_0000b0b0_0000e0e0_00000101_0000e0e0_0d_14
// stall bubble, then halt held two vectors
1_11_2_2_0_0_0_00_20_00_00_0e_00000001_00000002_00000000_0000b0b0_0000e0e0_00000003_00000002_0e_14
1_55_2_2_0_0_0_00_20_00_00_0f_00000010_00000020_00000000_0000b0b0_0000e0e0_00000030_00000020_0f_10
1_31_2_0_1_0_0_00_20_00_00_10_00000100_00000200_00000000_0000b0b0_0000e0e0_00000030_00000020_0f_10
1_39_2_0_1_0_0_00_20_00_00_11_00000300_00000400_00000000_0000b0b0_0000e0e0_00000030_00000020_0f_10
1_11_2_2_0_0_0_00_20_00_00_12_00000007_00000008_00000000_0000b0b0_0000e0e0_0000000f_00000008_12_14
// destination select, pass-through, unknown function
1_11_2_0_1_0_0_00_20_00_13_14_00000000_00000000_00000000_0000b0b0_0000e0e0_00000000_00000000_14_24
1_01_2_1_0_0_0_00_20_00_15_16_00000001_00000001_00000000_0000b0b0_0000e0e0_00000002_00000001_15_0c
1_11_2_2_0_0_0_00_18_00_00_17_00000005_00000006_00000000_0000b0b0_0000e0e0_00000000_00000006_17_14

/* sim.f */
+incdir+common
common/ex_pkg.sv
rtl/alu_op_decode.sv
rtl/operand_select.sv
alu/alu.sv
rtl/ex_mem_reg.sv
rtl/ex_stage.sv
bench/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - include_dirs:
      - common
    files:
      - common/ex_pkg.sv
      - rtl/alu_op_decode.sv
      - rtl/operand_select.sv
      - alu/alu.sv
      - rtl/ex_mem_reg.sv
      - rtl/ex_stage.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/ex_stage_tb.sv

/* bench/ex_stage_tb.sv */
`timescale 1ns/1ns

module ex_stage_tb;

    localparam int N_RANDOM   = 40;
    localparam int N_DIRECTED = 2;
    localparam int MAX_VEC    = 64;
    localparam VEC_FILE       = "bench/ex_stage_input.txt";

    logic clk;
    logic i_reset, i_stall, i_halt;
    logic i_reg_dst, i_mem2reg, i_mem_write, i_immediate_flag, i_reg_write, i_sign_flag;
    logic [5:0] i_opcode, i_func;
    logic [4:0] i_shamt;
    ex_pkg::reg_addr_t  i_rt, i_rd, o_write_reg;
    ex_pkg::data_t      i_reg_da, i_reg_db, i_immediate, i_output_memwb, i_output_exmem;
    ex_pkg::alu_class_e i_alu_class;
    ex_pkg::mem_width_e i_width, o_width;
    ex_pkg::fwd_sel_e   i_fw_a, i_fw_b;
    logic o_mem2reg, o_mem_write, o_reg_write, o_sign_flag;
    ex_pkg::data_t      o_result, o_data4mem;

    // one 312-bit word per vector line of the data file
    logic [311:0] vec_mem [0:MAX_VEC-1];
    int n_vectors;
    int cycle_count;
    int cycle_limit;
    int test_id;
    logic [31:0] rng_state;

    ex_stage uut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            abort_run();
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // zero forwarding code gives a zero operand
    function automatic logic [31:0] pick_operand(input logic [1:0] sel,
        input logic [31:0] reg_val, input logic [31:0] wb, input logic [31:0] em);
        case (sel)
            2'b00: return reg_val;
            2'b10: return wb;
            2'b11: return em;
            default: return 32'h0;
        endcase
    endfunction

    // kind 0 to 4 selects add, and, or, xor or slt
    function automatic logic [31:0] model_result(input int kind,
        input logic [31:0] a, input logic [31:0] b);
        case (kind)
            0: return a + b;
            1: return a & b;
            2: return a | b;
            3: return a ^ b;
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // opcode for i-type, function code for r-type
    function automatic logic [7:0] code_for(input int kind, input logic itype);
        case (kind)
            0: return itype ? 8'h08 : 8'h20;
            1: return itype ? 8'h0c : 8'h24;
            2: return itype ? 8'h0d : 8'h25;
            3: return itype ? 8'h0e : 8'h26;
            default: return itype ? 8'h0a : 8'h2a;
        endcase
    endfunction

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_data(input string name, input ex_pkg::data_t got,
        input ex_pkg::data_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h (test %0d)", name, got, exp, test_id);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input ex_pkg::reg_addr_t got,
        input ex_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h (test %0d)", name, got, exp, test_id);
            abort_run();
        end
    endtask

    task automatic check_ctrl(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h (test %0d)", name, got, exp, test_id);
            abort_run();
        end
    endtask

    task automatic check_width(input string name, input ex_pkg::mem_width_e got,
        input ex_pkg::mem_width_e exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h (test %0d)", name, got, exp, test_id);
            abort_run();
        end
    endtask

    // drive one vector, let the register capture it, then check
    task automatic run_vector(input logic [311:0] vec);
        logic [3:0]  cls, wid, sgn, fwa, fwb;
        logic [7:0]  ctl, op, fn, sh, rt, rd, wr, ex;
        logic [31:0] da, db, imm, wb, em, res, d4m;
        {ctl, cls, wid, sgn, fwa, fwb, op, fn, sh, rt, rd,
         da, db, imm, wb, em, res, d4m, wr, ex} = vec[307:0];
        @(posedge clk);
        i_stall          <= ctl[6];
        i_halt           <= ctl[5];
        i_reg_dst        <= ctl[4];
        i_mem2reg        <= ctl[3];
        i_mem_write      <= ctl[2];
        i_immediate_flag <= ctl[1];
        i_reg_write      <= ctl[0];
        i_alu_class      <= ex_pkg::alu_class_e'(cls[1:0]);
        i_width          <= ex_pkg::mem_width_e'(wid[1:0]);
        i_sign_flag      <= sgn[0];
        i_fw_a           <= ex_pkg::fwd_sel_e'(fwa[1:0]);
        i_fw_b           <= ex_pkg::fwd_sel_e'(fwb[1:0]);
        i_opcode         <= op[5:0];
        i_func           <= fn[5:0];
        i_shamt          <= sh[4:0];
        i_rt             <= rt[4:0];
        i_rd             <= rd[4:0];
        i_reg_da         <= da;
        i_reg_db         <= db;
        i_immediate      <= imm;
        i_output_memwb   <= wb;
        i_output_exmem   <= em;
        @(posedge clk);
        @(negedge clk);
        check_data("o_result", o_result, res);
        check_data("o_data4mem", o_data4mem, d4m);
        check_reg("o_write_reg", o_write_reg, wr[4:0]);
        check_ctrl("o_reg_write", o_reg_write, ex[2]);
        check_ctrl("o_mem_write", o_mem_write, ex[1]);
        check_ctrl("o_mem2reg", o_mem2reg, ex[0]);
        check_ctrl("o_sign_flag", o_sign_flag, ex[5]);
        check_width("o_width", o_width, ex_pkg::mem_width_e'(ex[4:3]));
    endtask

    task automatic run_random();
        logic [31:0] da, db, imm, wb, em, a, fb, b, res;
        logic [7:0]  ctl, cls, op, fn, rt, rd, wr;
        logic [1:0]  fwa, fwb;
        logic        itype;
        int          kind;
        rng_state = lcg_next(rng_state);
        da = rng_state;
        rng_state = lcg_next(rng_state);
        db = rng_state;
        rng_state = lcg_next(rng_state);
        imm = rng_state;
        rng_state = lcg_next(rng_state);
        wb = rng_state;
        rng_state = lcg_next(rng_state);
        em = rng_state;
        rng_state = lcg_next(rng_state);
        kind  = rng_state[15:8] % 5;
        itype = rng_state[20];
        fwa   = rng_state[22:21];
        fwb   = rng_state[24:23];
        rt    = {3'b000, rng_state[29:25]};
        rd    = {3'b000, rng_state[7:3]};
        a   = pick_operand(fwa, da, wb, em);
        fb  = pick_operand(fwb, db, wb, em);
        b   = itype ? imm : fb;
        res = model_result(kind, a, b);
        ctl = itype ? 8'h03 : 8'h11;
        cls = itype ? 8'h03 : 8'h02;
        op  = itype ? code_for(kind, 1'b1) : {2'b00, ex_pkg::op_r_type};
        fn  = itype ? 8'h00 : code_for(kind, 1'b0);
        wr  = itype ? rt : rd;
        run_vector({4'h1, ctl, cls[3:0], 4'h2, 4'h0, {2'b00, fwa}, {2'b00, fwb}, op, fn,
                    8'h00, rt, rd, da, db, imm, wb, em, res, fb, wr, 8'h14});
    endtask

    initial begin
        int fd;
        clk = 1'b0;
        i_reset = 1'b1;
        i_stall = 1'b0;
        i_halt = 1'b0;
        i_reg_dst = 1'b0;
        i_mem2reg = 1'b0;
        i_mem_write = 1'b0;
        i_immediate_flag = 1'b0;
        i_reg_write = 1'b0;
        i_sign_flag = 1'b0;
        i_opcode = '0;
        i_func = '0;
        i_shamt = '0;
        i_rt = '0;
        i_rd = '0;
        i_reg_da = '0;
        i_reg_db = '0;
        i_immediate = '0;
        i_output_memwb = '0;
        i_output_exmem = '0;
        i_alu_class = ex_pkg::class_load_store;
        i_width = ex_pkg::width_byte;
        i_fw_a = ex_pkg::fwd_reg_file;
        i_fw_b = ex_pkg::fwd_reg_file;
        cycle_count = 0;
        cycle_limit = 0;
        test_id = 0;
        rng_state = 32'd41;

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open vector file %s", VEC_FILE);
            abort_run();
        end
        $fclose(fd);
        $readmemh(VEC_FILE, vec_mem);
        n_vectors = 0;
        while (n_vectors < MAX_VEC && vec_mem[n_vectors][311:308] === 4'h1) begin
            n_vectors++;
        end
        if (n_vectors == 0) begin
            $display("no usable vectors found in %s", VEC_FILE);
            abort_run();
        end
        cycle_limit = (n_vectors + N_DIRECTED + N_RANDOM) * 2 + 50;

        repeat (10) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        check_ctrl("o_reg_write", o_reg_write, 1'b0);
        check_ctrl("o_mem_write", o_mem_write, 1'b0);
        check_ctrl("o_mem2reg", o_mem2reg, 1'b0);
        check_data("o_result", o_result, '0);

        for (int i = 0; i < n_vectors; i++) begin
            test_id = i + 1;
            run_vector(vec_mem[i]);
        end

        // stall with every control bit set clears all three
        test_id = n_vectors + 1;
        run_vector({4'h1, 8'h4d, 4'h2, 4'h2, 4'h0, 4'h0, 4'h0, 8'h00, 8'h20, 8'h00,
                    8'h01, 8'h02, 32'h00000001, 32'h00000002, 32'h00000000,
                    32'h0000b0b0, 32'h0000e0e0, 32'h00000003, 32'h00000002, 8'h01, 8'h10});
        // halt wins over a stall in the same cycle
        test_id = n_vectors + 2;
        run_vector({4'h1, 8'h7d, 4'h2, 4'h0, 4'h1, 4'h0, 4'h0, 8'h00, 8'h20, 8'h00,
                    8'h03, 8'h04, 32'h00000010, 32'h00000020, 32'h00000000,
                    32'h0000b0b0, 32'h0000e0e0, 32'h00000003, 32'h00000002, 8'h01, 8'h10});

        for (int i = 0; i < N_RANDOM; i++) begin
            test_id = n_vectors + N_DIRECTED + i + 1;
            run_random();
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* rtl/ex_stage.sv */
`timescale 1ns/1ns
`include "ex_macros.svh"

module ex_stage (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_stall,
    input  logic                        i_halt,
    input  ex_pkg::reg_addr_t           i_rt,
    input  ex_pkg::reg_addr_t           i_rd,
    input  ex_pkg::data_t               i_reg_da,
    input  ex_pkg::data_t               i_reg_db,
    input  ex_pkg::data_t               i_immediate,
    input  logic [`EX_NB_OP-1:0]        i_opcode,
    input  logic [`EX_NB_SHAMT-1:0]     i_shamt,
    input  logic [`EX_NB_OP-1:0]        i_func,
    // control unit
    input  logic                        i_reg_dst,
    input  logic                        i_mem2reg,
    input  logic                        i_mem_write,
    input  logic                        i_immediate_flag,
    input  logic                        i_reg_write,
    input  ex_pkg::alu_class_e          i_alu_class,
    input  ex_pkg::mem_width_e          i_width,
    input  logic                        i_sign_flag,
    // forwarding unit
    input  ex_pkg::fwd_sel_e            i_fw_a,
    input  ex_pkg::fwd_sel_e            i_fw_b,
    input  ex_pkg::data_t               i_output_memwb,
    input  ex_pkg::data_t               i_output_exmem,
    output logic                        o_mem2reg,
    output logic                        o_mem_write,
    output logic                        o_reg_write,
    output logic                        o_sign_flag,
    output ex_pkg::mem_width_e          o_width,
    output ex_pkg::data_t               o_result,
    output ex_pkg::data_t               o_data4mem,
    output ex_pkg::reg_addr_t           o_write_reg
);

    ex_pkg::alu_op_e    alu_op;
    ex_pkg::data_t      dato_a;
    ex_pkg::data_t      dato_b;
    ex_pkg::data_t      data4mem;
    ex_pkg::data_t      alu_result;

    alu_op_decode u_alu_op_decode (
        .i_alu_class (i_alu_class),
        .i_func      (i_func),
        .i_opcode    (i_opcode),
        .o_alu_op    (alu_op)
    );

    operand_select u_operand_select (
        .i_fw_a           (i_fw_a),
        .i_fw_b           (i_fw_b),
        .i_reg_da         (i_reg_da),
        .i_reg_db         (i_reg_db),
        .i_output_exmem   (i_output_exmem),
        .i_output_memwb   (i_output_memwb),
        .i_immediate      (i_immediate),
        .i_opcode         (i_opcode),
        .i_func           (i_func),
        .i_immediate_flag (i_immediate_flag),
        .o_dato_a         (dato_a),
        .o_dato_b         (dato_b),
        .o_data4mem       (data4mem)
    );

    alu u_alu (
        .i_op     (alu_op),
        .i_dato_a (dato_a),
        .i_dato_b (dato_b),
        .i_shamt  (i_shamt),
        .o_result (alu_result)
    );

    // one cycle from operands to the memory stage
    ex_mem_reg u_ex_mem_reg (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_halt      (i_halt),
        .i_stall     (i_stall),
        .i_mem2reg   (i_mem2reg),
        .i_mem_write (i_mem_write),
        .i_reg_write (i_reg_write),
        .i_reg_dst   (i_reg_dst),
        .i_sign_flag (i_sign_flag),
        .i_width     (i_width),
        .i_result    (alu_result),
        .i_data4mem  (data4mem),
        .i_rt        (i_rt),
        .i_rd        (i_rd),
        .o_mem2reg   (o_mem2reg),
        .o_mem_write (o_mem_write),
        .o_reg_write (o_reg_write),
        .o_sign_flag (o_sign_flag),
        .o_width     (o_width),
        .o_result    (o_result),
        .o_data4mem  (o_data4mem),
        .o_write_reg (o_write_reg)
    );

endmodule

/* rtl/ex_mem_reg.sv */
`timescale 1ns/1ns

module ex_mem_reg (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_halt,
    input  logic                    i_stall,
    input  logic                    i_mem2reg,
    input  logic                    i_mem_write,
    input  logic                    i_reg_write,
    input  logic                    i_reg_dst,
    input  logic                    i_sign_flag,
    input  ex_pkg::mem_width_e      i_width,
    input  ex_pkg::data_t           i_result,
    input  ex_pkg::data_t           i_data4mem,
    input  ex_pkg::reg_addr_t       i_rt,
    input  ex_pkg::reg_addr_t       i_rd,
    output logic                    o_mem2reg,
    output logic                    o_mem_write,
    output logic                    o_reg_write,
    output logic                    o_sign_flag,
    output ex_pkg::mem_width_e      o_width,
    output ex_pkg::data_t           o_result,
    output ex_pkg::data_t           o_data4mem,
    output ex_pkg::reg_addr_t       o_write_reg
);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_mem2reg   <= 1'b0;
            o_mem_write <= 1'b0;
            o_reg_write <= 1'b0;
            o_sign_flag <= 1'b0;
            o_width     <= ex_pkg::width_byte;
            o_result    <= '0;
            o_data4mem  <= '0;
            o_write_reg <= '0;
        end else if (!i_halt) begin
            // a stall turns this slot into a bubble
            o_mem2reg   <= i_stall ? 1'b0 : i_mem2reg;
            o_mem_write <= i_stall ? 1'b0 : i_mem_write;
            o_reg_write <= i_stall ? 1'b0 : i_reg_write;

            o_sign_flag <= i_sign_flag;
            o_width     <= i_width;
            o_result    <= i_result;
            o_data4mem  <= i_data4mem;
            // rd for r-type, rt otherwise
            o_write_reg <= i_reg_dst ? i_rd : i_rt;
        end
    end

    // halt freezes the whole register
    a_halt_hold: assert property (
        @(posedge clk) disable iff (i_reset)
        i_halt |=> $stable({o_mem2reg, o_mem_write, o_reg_write, o_sign_flag,
                            o_width, o_result, o_data4mem, o_write_reg})
    ) else $error("ex/mem outputs changed during halt");

    // no register write may leave a bubble
    a_stall_bubble: assert property (
        @(posedge clk) disable iff (i_reset)
        (i_stall && !i_halt) |=> !o_reg_write
    ) else $error("register write after stall");

endmodule

/* alu/alu.sv */
`timescale 1ns/1ns
`include "ex_macros.svh"

module alu (
    input  ex_pkg::alu_op_e             i_op,
    input  ex_pkg::data_t               i_dato_a,
    input  ex_pkg::data_t               i_dato_b,
    input  logic [`EX_NB_SHAMT-1:0]     i_shamt,
    output ex_pkg::data_t               o_result
);

    localparam int LUI_SHIFT = `EX_NB_DATA / 2;

    logic                       lt_signed;
    logic                       lt_unsigned;
    logic [`EX_NB_SHAMT-1:0]    var_shamt;
    ex_pkg::data_t              sum;
    ex_pkg::data_t              diff;

    // compare results for slt family
    assign lt_signed   = $signed(i_dato_a) < $signed(i_dato_b);
    assign lt_unsigned = i_dato_a < i_dato_b;

    // variable shifts take rs low bits
    assign var_shamt = i_dato_a[`EX_NB_SHAMT-1:0];

    // wrap-around, no overflow trap
    assign sum  = i_dato_a + i_dato_b;
    assign diff = i_dato_a - i_dato_b;

    always_comb begin
        case (i_op)
            ex_pkg::alu_add, ex_pkg::alu_addu,
            ex_pkg::alu_addi, ex_pkg::alu_addiu:
                o_result = sum;
            ex_pkg::alu_sub, ex_pkg::alu_subu:
                o_result = diff;

            ex_pkg::alu_and, ex_pkg::alu_andi:
                o_result = i_dato_a & i_dato_b;
            ex_pkg::alu_or, ex_pkg::alu_ori:
                o_result = i_dato_a | i_dato_b;
            ex_pkg::alu_xor, ex_pkg::alu_xori:
                o_result = i_dato_a ^ i_dato_b;
            ex_pkg::alu_nor:
                o_result = ~(i_dato_a | i_dato_b);

            // set less than gives 1 or 0
            ex_pkg::alu_slt, ex_pkg::alu_slti:
                o_result = {{(`EX_NB_DATA-1){1'b0}}, lt_signed};
            ex_pkg::alu_sltu, ex_pkg::alu_sltiu:
                o_result = {{(`EX_NB_DATA-1){1'b0}}, lt_unsigned};

            // shifts act on rt, which arrives as operand b
            ex_pkg::alu_sll:
                o_result = i_dato_b << i_shamt;
            ex_pkg::alu_srl:
                o_result = i_dato_b >> i_shamt;
            ex_pkg::alu_sra:
                o_result = $signed(i_dato_b) >>> i_shamt;
            ex_pkg::alu_sllv:
                o_result = i_dato_b << var_shamt;
            ex_pkg::alu_srlv:
                o_result = i_dato_b >> var_shamt;
            ex_pkg::alu_srav:
                o_result = $signed(i_dato_b) >>> var_shamt;

            // immediate into the upper half
            ex_pkg::alu_lui:
                o_result = i_dato_b << LUI_SHIFT;

            ex_pkg::alu_idle:
                o_result = '0;
            default:
                o_result = '0;
        endcase
    end

endmodule

/* rtl/operand_select.sv */
`timescale 1ns/1ns
`include "ex_macros.svh"

module operand_select (
    input  ex_pkg::fwd_sel_e        i_fw_a,
    input  ex_pkg::fwd_sel_e        i_fw_b,
    input  ex_pkg::data_t           i_reg_da,
    input  ex_pkg::data_t           i_reg_db,
    input  ex_pkg::data_t           i_output_exmem,
    input  ex_pkg::data_t           i_output_memwb,
    input  ex_pkg::data_t           i_immediate,
    input  logic [`EX_NB_OP-1:0]    i_opcode,
    input  logic [`EX_NB_OP-1:0]    i_func,
    input  logic                    i_immediate_flag,
    output ex_pkg::data_t           o_dato_a,
    output ex_pkg::data_t           o_dato_b,
    output ex_pkg::data_t           o_data4mem
);

    ex_pkg::data_t fwd_a;
    ex_pkg::data_t fwd_b;
    logic          is_link;

    // one forwarding mux, shared by both operands
    function automatic ex_pkg::data_t fwd_mux(
        input ex_pkg::fwd_sel_e sel,
        input ex_pkg::data_t    reg_val,
        input ex_pkg::data_t    memwb_val,
        input ex_pkg::data_t    exmem_val
    );
        case (sel)
            ex_pkg::fwd_reg_file: return reg_val;
            ex_pkg::fwd_mem_wb:   return memwb_val;
            ex_pkg::fwd_ex_mem:   return exmem_val;
            default:              return '0;
        endcase
    endfunction

    assign fwd_a = fwd_mux(i_fw_a, i_reg_da, i_output_memwb, i_output_exmem);
    assign fwd_b = fwd_mux(i_fw_b, i_reg_db, i_output_memwb, i_output_exmem);

    // jal and jalr take the register file values directly
    assign is_link = (i_opcode == ex_pkg::op_jal) ||
                     ((i_opcode == ex_pkg::op_r_type) && (i_func == ex_pkg::fn_jalr));

    assign o_dato_a = is_link ? i_reg_da : fwd_a;

    // immediate wins over both forwarding and the link bypass
    assign o_dato_b = i_immediate_flag ? i_immediate
                    : (is_link ? i_reg_db : fwd_b);

    // store data keeps the forwarded rt value
    assign o_data4mem = fwd_b;

    always_comb begin
        if (i_opcode == ex_pkg::op_jal) begin
            a_jal_bypass: assert final (o_dato_a == i_reg_da)
                else $error("jal operand a not taken from register file");
        end
    end

endmodule

/* rtl/alu_op_decode.sv */
`timescale 1ns/1ns
`include "ex_macros.svh"

module alu_op_decode (
    input  ex_pkg::alu_class_e      i_alu_class,
    input  logic [`EX_NB_OP-1:0]    i_func,
    input  logic [`EX_NB_OP-1:0]    i_opcode,
    output ex_pkg::alu_op_e         o_alu_op
);

    // function codes the alu understands
    function automatic logic is_r_op(input logic [`EX_NB_OP-1:0] code);
        case (code)
            ex_pkg::alu_sll, ex_pkg::alu_srl, ex_pkg::alu_sra,
            ex_pkg::alu_sllv, ex_pkg::alu_srlv, ex_pkg::alu_srav,
            ex_pkg::alu_add, ex_pkg::alu_addu, ex_pkg::alu_sub, ex_pkg::alu_subu,
            ex_pkg::alu_and, ex_pkg::alu_or, ex_pkg::alu_xor, ex_pkg::alu_nor,
            ex_pkg::alu_slt, ex_pkg::alu_sltu:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    // immediate opcodes the alu understands
    function automatic logic is_i_op(input logic [`EX_NB_OP-1:0] code);
        case (code)
            ex_pkg::alu_addi, ex_pkg::alu_addiu, ex_pkg::alu_slti, ex_pkg::alu_sltiu,
            ex_pkg::alu_andi, ex_pkg::alu_ori, ex_pkg::alu_xori, ex_pkg::alu_lui:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    always_comb begin
        o_alu_op = ex_pkg::alu_idle;
        case (i_alu_class)
            // loads, stores and link address all add
            ex_pkg::class_load_store: o_alu_op = ex_pkg::alu_add;
            ex_pkg::class_branch:     o_alu_op = ex_pkg::alu_idle;
            ex_pkg::class_r_type: begin
                if (is_r_op(i_func)) begin
                    o_alu_op = ex_pkg::alu_op_e'(i_func);
                end
            end
            ex_pkg::class_i_type: begin
                if (is_i_op(i_opcode)) begin
                    o_alu_op = ex_pkg::alu_op_e'(i_opcode);
                end
            end
            default: o_alu_op = ex_pkg::alu_idle;
        endcase
    end

    // known control fields must never reach the alu as x
    always_comb begin
        if (!$isunknown({i_alu_class, i_func, i_opcode})) begin
            a_op_known: assert final (!$isunknown(o_alu_op))
                else $error("alu op unknown for known inputs");
        end
    end

endmodule

/* common/ex_pkg.sv */
`include "ex_macros.svh"

package ex_pkg;

    typedef logic [`EX_NB_DATA-1:0] data_t;
    typedef logic [`EX_NB_REG-1:0]  reg_addr_t;

    // alu class from the control unit
    typedef enum logic [1:0] {
        class_load_store = 2'b00,
        class_branch     = 2'b01,
        class_r_type     = 2'b10,
        class_i_type     = 2'b11
    } alu_class_e;

    // r-type entries carry the function code, immediate entries the opcode
    typedef enum logic [`EX_NB_OP-1:0] {
        alu_sll   = 6'b000000,
        alu_srl   = 6'b000010,
        alu_sra   = 6'b000011,
        alu_sllv  = 6'b000100,
        alu_srlv  = 6'b000110,
        alu_srav  = 6'b000111,
        alu_add   = 6'b100000,
        alu_addu  = 6'b100001,
        alu_sub   = 6'b100010,
        alu_subu  = 6'b100011,
        alu_and   = 6'b100100,
        alu_or    = 6'b100101,
        alu_xor   = 6'b100110,
        alu_nor   = 6'b100111,
        alu_slt   = 6'b101010,
        alu_sltu  = 6'b101011,
        alu_addi  = 6'b001000,
        alu_addiu = 6'b001001,
        alu_slti  = 6'b001010,
        alu_sltiu = 6'b001011,
        alu_andi  = 6'b001100,
        alu_ori   = 6'b001101,
        alu_xori  = 6'b001110,
        alu_lui   = 6'b001111,
        alu_idle  = 6'b111111
    } alu_op_e;

    // forwarding unit operand source
    typedef enum logic [1:0] {
        fwd_reg_file = 2'b00,
        fwd_zero     = 2'b01,
        fwd_mem_wb   = 2'b10,
        fwd_ex_mem   = 2'b11
    } fwd_sel_e;

    typedef enum logic [1:0] {
        width_byte = 2'b00,
        width_half = 2'b01,
        width_word = 2'b10
    } mem_width_e;

    // jump-and-link detection
    localparam logic [`EX_NB_OP-1:0] op_r_type = 6'b000000;
    localparam logic [`EX_NB_OP-1:0] op_jal    = 6'b000011;
    localparam logic [`EX_NB_OP-1:0] fn_jalr   = 6'b001001;

endpackage

/* common/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// execute stage widths

// data path, one machine word
`define EX_NB_DATA 32

// register file index
`define EX_NB_REG 5

// opcode and function fields share one width
`define EX_NB_OP 6

// constant shift amount from the instruction
`define EX_NB_SHAMT 5

`endif
